// ==== compile.f ====
+incdir+include
rtl/lockstep_pkg.sv
rtl/core_out_if.sv
rtl/acc_core.sv
rtl/lockstep_reset_ctrl.sv
rtl/lockstep_delay_line.sv
rtl/lockstep_compare.sv
rtl/lockstep_top.sv
dv/lockstep_asserts.sv
dv/lockstep_tb.sv

// ==== dv/lockstep_asserts.sv ====
`timescale 1ns/1ps

module lockstep_asserts (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                shadow_rst_ni,
  input lockstep_pkg::mubi_t cmp_en_i
);

  // Number of failed properties so far
  int unsigned fail_cnt = 0;

  // Only the two legal encodings may appear on the enable
  a_en_encoding: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cmp_en_i == lockstep_pkg::MUBI_ON) || (cmp_en_i == lockstep_pkg::MUBI_OFF)
  ) else begin
    $error("Compare enable holds illegal encoding 0x%0h", cmp_en_i);
    fail_cnt++;
  end

  // Comparison never runs against a shadow core held in reset
  a_en_needs_release: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cmp_en_i != lockstep_pkg::MUBI_OFF) |-> shadow_rst_ni
  ) else begin
    $error("Compare enable active while the shadow core is in reset");
    fail_cnt++;
  end

  // The enable turns on only after the release was already visible
  a_en_rise_order: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_i == lockstep_pkg::MUBI_ON) |-> $past(shadow_rst_ni)
  ) else begin
    $error("Compare enable rose before the shadow reset was released");
    fail_cnt++;
  end

endmodule

// ==== dv/lockstep_tb.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

module lockstep_tb;

  localparam int unsigned ClkPeriod  = 100;
  localparam int unsigned RstCycles  = 3;
  localparam int unsigned RandCycles = 200;
  localparam int unsigned OpW        = `LS_OP_W;
  localparam int unsigned DataW      = `LS_DATA_W;
  localparam int unsigned OutW       = 3 + DataW;
  // Main sample to alert distance
  localparam int unsigned Lag        = `LS_OFFSET + 1;

  // Cycles of all tests together
  localparam int unsigned TestCycles = (RstCycles + 22) + (RandCycles + 6) +
                                       4 * (Lag + 6) + (RstCycles + 22) +
                                       (RstCycles + 2 * Lag + 16);
  localparam int unsigned MaxCycles  = 2 * TestCycles;

  logic              clk;
  logic              rst_n;
  logic              cmd_valid;
  lockstep_pkg::op_e cmd_op;
  logic [DataW-1:0]  cmd_data;
  logic              core_res_valid;
  logic [DataW-1:0]  core_acc;
  logic              core_zero;
  logic              core_carry;
  logic              alert_major;
  logic              alert_minor;

  // Main core model and the command it applies on the next edge
  logic [DataW-1:0]  m_acc;
  logic              m_carry, m_zero, m_res_valid, m_minor;
  logic              p_valid;
  logic [OpW-1:0]    p_op;
  logic [DataW-1:0]  p_data;

  // Expected alerts per cycle, oldest first
  logic exp_major_q[$];
  logic exp_minor_q[$];

  int unsigned cycle_cnt;

  lockstep_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cmd_valid_i      (cmd_valid),
    .cmd_op_i         (cmd_op),
    .cmd_data_i       (cmd_data),
    .core_res_valid_i (core_res_valid),
    .core_acc_i       (core_acc),
    .core_zero_i      (core_zero),
    .core_carry_i     (core_carry),
    .alert_major_o    (alert_major),
    .alert_minor_o    (alert_minor)
  );

  bind lockstep_reset_ctrl lockstep_asserts u_asserts (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_ni (shadow_rst_no),
    .cmp_en_i      (cmp_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      abort_run("Run exceeded its cycle budget");
    end
  end

  ////////////////////////////////////////
  // Checks and main core model
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("Some tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_alert(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run("Alert output mismatch");
    end
  endtask

  function automatic logic is_legal(input logic [OpW-1:0] op);
    return (op == lockstep_pkg::OP_NOP) || (op == lockstep_pkg::OP_ADD) ||
           (op == lockstep_pkg::OP_XOR) || (op == lockstep_pkg::OP_LOAD);
  endfunction

  task automatic clear_model();
    m_acc       = '0;
    m_carry     = 1'b0;
    m_zero      = 1'b0;
    m_res_valid = 1'b0;
    m_minor     = 1'b0;
    p_valid     = 1'b0;
    p_op        = '0;
    p_data      = '0;
    {core_res_valid, core_acc, core_zero, core_carry} = '0;
    exp_major_q.delete();
    exp_minor_q.delete();
    repeat (Lag) begin
      exp_major_q.push_back(1'b0);
      exp_minor_q.push_back(1'b0);
    end
  endtask

  // Main core register update for the command applied at the last rising edge
  task automatic update_model();
    m_res_valid = p_valid;
    if (p_valid) begin
      case (p_op)
        lockstep_pkg::OP_ADD: begin
          {m_carry, m_acc} = {1'b0, m_acc} + {1'b0, p_data};
        end
        lockstep_pkg::OP_XOR: begin
          m_acc   = m_acc ^ p_data;
          m_carry = 1'b0;
        end
        lockstep_pkg::OP_LOAD: begin
          m_acc   = p_data;
          m_carry = 1'b0;
        end
        default: begin
          // NOP and illegal codes keep acc and carry
        end
      endcase
      m_zero = (m_acc == '0);
    end
  endtask

  // One cycle of alert checks, main outputs with optional bit flips and a new command
  task automatic step(input logic valid, input logic [OpW-1:0] op,
                      input logic [DataW-1:0] data, input logic [OutW-1:0] flip);
    @(negedge clk);
    check_alert("alert_major_o", alert_major, exp_major_q.pop_front());
    check_alert("alert_minor_o", alert_minor, exp_minor_q.pop_front());
    update_model();
    {core_res_valid, core_acc, core_zero, core_carry} =
        {m_res_valid, m_acc, m_zero, m_carry} ^ flip;
    cmd_valid = valid;
    cmd_op    = lockstep_pkg::op_e'(op);
    cmd_data  = data;
    p_valid   = valid;
    p_op      = op;
    p_data    = data;
    if (valid && !is_legal(op)) begin
      m_minor = 1'b1;
    end
    exp_major_q.push_back(|flip);
    exp_minor_q.push_back(m_minor);
  endtask

  task automatic run_idle(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      step(1'b0, lockstep_pkg::OP_NOP, '0, '0);
    end
  endtask

  task automatic random_step(input logic [OutW-1:0] flip);
    logic             valid;
    logic [OpW-1:0]   op;
    logic [DataW-1:0] data;
    valid = ($urandom_range(3, 0) != 0);
    op    = OpW'($urandom_range(3, 0));
    data  = DataW'($urandom());
    step(valid, op, data, flip);
  endtask

  task automatic apply_reset(input logic garbage);
    @(negedge clk);
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = lockstep_pkg::OP_NOP;
    cmd_data  = '0;
    clear_model();
    for (int unsigned i = 0; i < RstCycles; i++) begin
      if (garbage) begin
        {core_res_valid, core_acc, core_zero, core_carry} = OutW'({$urandom(), $urandom()});
      end
      @(negedge clk);
      check_alert("alert_major_o", alert_major, 1'b0);
      check_alert("alert_minor_o", alert_minor, 1'b0);
    end
    rst_n = 1'b1;
    clear_model();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_quiet();
    apply_reset(1'b0);
    run_idle(20);
  endtask

  task automatic test_random_stream();
    // All ones plus one wraps to zero with a carry
    step(1'b1, lockstep_pkg::OP_LOAD, '1, '0);
    step(1'b1, lockstep_pkg::OP_ADD, DataW'(1), '0);
    step(1'b1, lockstep_pkg::OP_XOR, DataW'($urandom()), '0);
    step(1'b1, lockstep_pkg::OP_NOP, DataW'($urandom()), '0);
    for (int unsigned i = 0; i < RandCycles; i++) begin
      random_step('0);
    end
  endtask

  // Layout of the flip mask is {res_valid, acc, zero, carry}
  task automatic test_flip_detect();
    logic [OutW-1:0] flip;
    for (int unsigned f = 0; f < 4; f++) begin
      case (f)
        0:       flip = OutW'(1) << (2 + $urandom_range(DataW - 1, 0));
        1:       flip = OutW'(2);
        2:       flip = OutW'(1);
        default: flip = OutW'(1) << (OutW - 1);
      endcase
      random_step('0);
      random_step('0);
      random_step(flip);
      for (int unsigned i = 0; i < Lag + 3; i++) begin
        random_step('0);
      end
    end
  endtask

  task automatic test_reset_garbage();
    apply_reset(1'b1);
    for (int unsigned i = 0; i < 20; i++) begin
      random_step('0);
    end
  endtask

  task automatic test_illegal_op();
    random_step('0);
    step(1'b1, OpW'($urandom_range(7, 4)), DataW'($urandom()), '0);
    for (int unsigned i = 0; i < Lag + 8; i++) begin
      random_step('0);
    end
    // Sticky alert must clear only here
    apply_reset(1'b0);
    run_idle(Lag + 4);
  endtask

  initial begin
    void'($urandom(80995));
    cycle_cnt  = 0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = lockstep_pkg::OP_NOP;
    cmd_data   = '0;
    clear_model();

    test_reset_quiet();
    test_random_stream();
    test_flip_detect();
    test_reset_garbage();
    test_illegal_op();

    if (DUT.u_reset_ctrl.u_asserts.fail_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("Reset controller assertions failed");
    end
  end

endmodule

// ==== include/lockstep_cfg.svh ====
`ifndef LOCKSTEP_CFG_SVH
`define LOCKSTEP_CFG_SVH

// Cycles by which the shadow core trails the main core, must be 2 or more
`define LS_OFFSET 2

// Accumulator and command data width
`define LS_DATA_W 32

// Opcode field width
`define LS_OP_W 3

`endif

// ==== rtl/acc_core.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

module acc_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  lockstep_pkg::op_e     cmd_op_i,
  input  logic [`LS_DATA_W-1:0] cmd_data_i,
  core_out_if.src               res,
  output logic                  alert_minor_o
);

  logic [`LS_DATA_W-1:0] acc_d, acc_q;
  logic                  carry_d, carry_q;
  logic                  zero_q;
  logic                  res_valid_q;
  logic                  illegal_op;
  logic                  alert_q;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    acc_d      = acc_q;
    carry_d    = carry_q;
    illegal_op = 1'b0;
    case (cmd_op_i)
      lockstep_pkg::OP_NOP: begin
        acc_d = acc_q;
      end
      lockstep_pkg::OP_ADD: begin
        {carry_d, acc_d} = {1'b0, acc_q} + {1'b0, cmd_data_i};
      end
      lockstep_pkg::OP_XOR: begin
        acc_d   = acc_q ^ cmd_data_i;
        carry_d = 1'b0;
      end
      lockstep_pkg::OP_LOAD: begin
        acc_d   = cmd_data_i;
        carry_d = 1'b0;
      end
      // Unknown encodings behave as NOP
      default: begin
        illegal_op = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////
  // State and result registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      carry_q     <= 1'b0;
      zero_q      <= 1'b0;
      res_valid_q <= 1'b0;
      alert_q     <= 1'b0;
    end else begin
      res_valid_q <= cmd_valid_i;
      if (cmd_valid_i) begin
        acc_q   <= acc_d;
        carry_q <= carry_d;
        // Zero flag only refreshes on a command
        zero_q  <= (acc_d == '0);
      end
      // Sticky until reset
      if (cmd_valid_i && illegal_op) begin
        alert_q <= 1'b1;
      end
    end
  end

  assign res.res_valid  = res_valid_q;
  assign res.acc        = acc_q;
  assign res.zero       = zero_q;
  assign res.carry      = carry_q;
  assign alert_minor_o  = alert_q;

endmodule

// ==== rtl/core_out_if.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

interface core_out_if;

  logic                  res_valid;
  logic [`LS_DATA_W-1:0] acc;
  logic                  zero;
  logic                  carry;

  // Core side drives the results
  modport src (output res_valid, output acc, output zero, output carry);

  // Checker side only observes
  modport dst (input res_valid, input acc, input zero, input carry);

endinterface

// ==== rtl/lockstep_compare.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

module lockstep_compare (
  input  logic                clk_i,
  input  lockstep_pkg::mubi_t cmp_en_i,
  core_out_if.dst             shadow,
  core_out_if.dst             main,
  output logic                alert_major_o
);

  logic                  res_valid_q;
  logic [`LS_DATA_W-1:0] acc_q;
  logic                  zero_q;
  logic                  carry_q;
  logic                  mismatch;

  // One extra stage on the shadow side, matched by the longer main delay
  always_ff @(posedge clk_i) begin
    res_valid_q <= shadow.res_valid;
    acc_q       <= shadow.acc;
    zero_q      <= shadow.zero;
    carry_q     <= shadow.carry;
  end

  assign mismatch = (res_valid_q != main.res_valid) |
                    (acc_q       != main.acc)       |
                    (zero_q      != main.zero)      |
                    (carry_q     != main.carry);

  // A corrupted enable still counts as on
  assign alert_major_o = (cmp_en_i != lockstep_pkg::MUBI_OFF) & mismatch;

endmodule

// ==== rtl/lockstep_delay_line.sv ====
`timescale 1ns/1ps

module lockstep_delay_line #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  // Stage DEPTH-1 takes the new value, stage 0 is the oldest
  logic [DEPTH-1:0][WIDTH-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < DEPTH - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[DEPTH-1] <= data_i;
    end
  end

  assign data_o = stage_q[0];

endmodule

// ==== rtl/lockstep_pkg.sv ====
`include "lockstep_cfg.svh"

package lockstep_pkg;

  ////////////////////////////////////////
  // Multibit enable
  ////////////////////////////////////////

  localparam int unsigned MUBI_W = 4;

  typedef logic [MUBI_W-1:0] mubi_t;

  // Anything other than MUBI_OFF is treated as enabled
  localparam mubi_t MUBI_ON  = 4'b0101;
  localparam mubi_t MUBI_OFF = 4'b1010;

  ////////////////////////////////////////
  // Accumulator opcodes
  ////////////////////////////////////////

  // Encodings 4 to 7 are illegal and raise the minor alert
  typedef enum logic [`LS_OP_W-1:0] {
    OP_NOP  = 3'd0,
    OP_ADD  = 3'd1,
    OP_XOR  = 3'd2,
    OP_LOAD = 3'd3
  } op_e;

endpackage

// ==== rtl/lockstep_reset_ctrl.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

module lockstep_reset_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  output logic                shadow_rst_no,
  output lockstep_pkg::mubi_t cmp_en_o
);

  localparam int unsigned CntW = $clog2(`LS_OFFSET);
  localparam logic [CntW-1:0] CntMax = CntW'(`LS_OFFSET - 1);

  logic [CntW-1:0]     cnt_q;
  lockstep_pkg::mubi_t set_d, set_q;
  lockstep_pkg::mubi_t en_q;

  ////////////////////////////////////////
  // Offset counter
  ////////////////////////////////////////

  // Saturates once the shadow release point is reached
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CntMax) begin
      cnt_q <= cnt_q + CntW'(1);
    end
  end

  assign set_d = (cnt_q >= CntMax) ? lockstep_pkg::MUBI_ON : lockstep_pkg::MUBI_OFF;

  ////////////////////////////////////////
  // Release and enable flops
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_q <= lockstep_pkg::MUBI_OFF;
      en_q  <= lockstep_pkg::MUBI_OFF;
    end else begin
      set_q <= set_d;
      // Comparison starts one cycle after the shadow leaves reset
      en_q  <= set_q;
    end
  end

  // Asserts with rst_ni, releases on a clock edge
  assign shadow_rst_no = set_q[0];
  assign cmp_en_o      = en_q;

endmodule

// ==== rtl/lockstep_top.sv ====
`timescale 1ns/1ps
`include "lockstep_cfg.svh"

module lockstep_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Main core commands
  input  logic                  cmd_valid_i,
  input  lockstep_pkg::op_e     cmd_op_i,
  input  logic [`LS_DATA_W-1:0] cmd_data_i,

  // Main core results
  input  logic                  core_res_valid_i,
  input  logic [`LS_DATA_W-1:0] core_acc_i,
  input  logic                  core_zero_i,
  input  logic                  core_carry_i,

  output logic                  alert_major_o,
  output logic                  alert_minor_o
);

  localparam int unsigned CmdW = 1 + `LS_OP_W + `LS_DATA_W;
  localparam int unsigned OutW = 3 + `LS_DATA_W;

  logic                shadow_rst_n;
  lockstep_pkg::mubi_t cmp_en;
  logic [CmdW-1:0]     cmd_dly;
  logic [OutW-1:0]     main_out_dly;

  core_out_if shadow_out ();
  core_out_if main_dly ();

  ////////////////////////////////////////
  // Reset and enable sequencing
  ////////////////////////////////////////

  lockstep_reset_ctrl u_reset_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////////////////////////
  // Input delay and shadow core
  ////////////////////////////////////////

  lockstep_delay_line #(
    .WIDTH (CmdW),
    .DEPTH (`LS_OFFSET)
  ) u_in_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({cmd_valid_i, cmd_op_i, cmd_data_i}),
    .data_o (cmd_dly)
  );

  acc_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (shadow_rst_n),
    .cmd_valid_i   (cmd_dly[CmdW-1]),
    .cmd_op_i      (lockstep_pkg::op_e'(cmd_dly[`LS_DATA_W +: `LS_OP_W])),
    .cmd_data_i    (cmd_dly[`LS_DATA_W-1:0]),
    .res           (shadow_out.src),
    .alert_minor_o (alert_minor_o)
  );

  ////////////////////////////////////////
  // Main output delay
  ////////////////////////////////////////

  // One cycle longer to cover the shadow result register in the checker
  lockstep_delay_line #(
    .WIDTH (OutW),
    .DEPTH (`LS_OFFSET + 1)
  ) u_out_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({core_res_valid_i, core_acc_i, core_zero_i, core_carry_i}),
    .data_o (main_out_dly)
  );

  assign {main_dly.res_valid, main_dly.acc, main_dly.zero, main_dly.carry} = main_out_dly;

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  lockstep_compare u_compare (
    .clk_i         (clk_i),
    .cmp_en_i      (cmp_en),
    .shadow        (shadow_out.dst),
    .main          (main_dly.dst),
    .alert_major_o (alert_major_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the lockstep testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module lockstep_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vlockstep_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^All tests passed$"; then
  exit 0
fi
echo "Pass line missing from simulation output"
exit 1
